// File: logic/sam_mem_pkg.sv
`default_nettype none

package sam_mem_pkg;

    ////////////////////
    // Memory map
    ////////////////////

    localparam int RAM_AW  = 19;
    localparam int AXIL_AW = 20;
    localparam int AXIL_DW = 32;

    // Byte addresses below this one go to RAM
    localparam logic [AXIL_AW-1:0] REG_BASE = 20'h80000;

    // Register offsets inside the register space
    localparam logic [RAM_AW-1:0] PAL_OFFS    = 19'h00;
    localparam logic [RAM_AW-1:0] MODE_OFFS   = 19'h40;
    localparam logic [RAM_AW-1:0] BASE_OFFS   = 19'h44;
    localparam logic [RAM_AW-1:0] BORDER_OFFS = 19'h48;

    ////////////////////
    // AXI4-Lite channels
    ////////////////////

    // Master side, all five channels
    typedef struct packed {
        logic               aw_valid;
        logic [AXIL_AW-1:0] aw_addr;
        logic               w_valid;
        logic [AXIL_DW-1:0] w_data;
        logic [3:0]         w_strb;
        logic               b_ready;
        logic               ar_valid;
        logic [AXIL_AW-1:0] ar_addr;
        logic               r_ready;
    } axil_req_t;

    // Slave side
    typedef struct packed {
        logic               aw_ready;
        logic               w_ready;
        logic               b_valid;
        logic [1:0]         b_resp;
        logic               ar_ready;
        logic               r_valid;
        logic [AXIL_DW-1:0] r_data;
        logic [1:0]         r_resp;
    } axil_rsp_t;

    ////////////////////
    // Arbiter ports
    ////////////////////

    typedef struct packed {
        logic              valid;
        logic              we;
        logic [RAM_AW-1:0] addr;
        logic [7:0]        wdata;
    } mem_req_t;

    // Read byte comes back one clock after the grant
    typedef struct packed {
        logic       grant;
        logic       rvalid;
        logic [7:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: logic/sam_video_pkg.sv
`default_nettype none

package sam_video_pkg;

    ////////////////////
    // Raster timing
    ////////////////////

    // Reduced raster, short frames in simulation
    localparam int H_TOTAL     = 48;
    localparam int H_ACTIVE    = 32;
    localparam int HSYNC_START = 36;
    localparam int HSYNC_END   = 40;
    localparam int V_TOTAL     = 24;
    localparam int V_ACTIVE    = 16;
    localparam int VSYNC_START = 18;
    localparam int VSYNC_END   = 20;
    localparam int X_W         = 6;
    localparam int Y_W         = 5;

    // Bytes per line in mode 4, mode 2 needs only 4
    localparam int LINE_BYTES  = 16;
    localparam int PAL_ENTRIES = 16;

    ////////////////////
    // Modes and colour
    ////////////////////

    typedef enum logic {
        MODE2 = 1'b0,
        MODE4 = 1'b1
    } mode_e;

    typedef struct packed {
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
        logic       bright;
    } colour_t;

    // Display control as seen by the fetcher and palette
    typedef struct packed {
        mode_e                         mode;
        logic [sam_mem_pkg::RAM_AW-1:0] base;
        logic [3:0]                    border;
    } video_ctrl_t;

    // One-clock palette update
    typedef struct packed {
        logic       valid;
        logic [3:0] idx;
        colour_t    colour;
    } pal_wr_t;

    // Screen byte, two nibbles in mode 4, bitmap in mode 2 (bit 7 leftmost)
    typedef union packed {
        struct packed {
            logic [3:0] hi;
            logic [3:0] lo;
        } nib;
        logic [7:0] bits;
    } screen_byte_u;

endpackage

`default_nettype wire

// File: logic/cpu_bus_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_bus_bridge (
    input  wire                       clk12,
    input  wire                       arst_n,
    input  wire sam_mem_pkg::axil_req_t axil_req,
    output sam_mem_pkg::axil_rsp_t    axil_rsp,
    output sam_mem_pkg::mem_req_t     mem_req,
    input  wire sam_mem_pkg::mem_rsp_t  mem_rsp,
    output sam_video_pkg::video_ctrl_t video_ctrl,
    output sam_video_pkg::pal_wr_t    pal_wr
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RAM_WAIT,
        ST_RD_WAIT,
        ST_WR_RESP,
        ST_RD_RESP
    } state_e;

    state_e state;
    logic   op_wr;
    logic   wr_req;
    logic   rd_req;
    logic   wr_is_reg;
    logic   rd_is_reg;
    logic   wr_is_pal;
    logic   reg_wr_en;
    logic [sam_mem_pkg::RAM_AW-1:0]  wr_offs;
    logic [sam_mem_pkg::RAM_AW-1:0]  rd_offs;
    logic [sam_mem_pkg::AXIL_DW-1:0] r_data_q;
    sam_video_pkg::colour_t pal_shadow [sam_video_pkg::PAL_ENTRIES];

    // Register read mux, unmapped offsets give zero
    function automatic logic [sam_mem_pkg::AXIL_DW-1:0] reg_read(
        input logic [sam_mem_pkg::RAM_AW-1:0] offs
    );
        logic [sam_mem_pkg::AXIL_DW-1:0] d;
        d = '0;
        if (offs[sam_mem_pkg::RAM_AW-1:6] == sam_mem_pkg::PAL_OFFS[sam_mem_pkg::RAM_AW-1:6]
            && offs[1:0] == 2'b00) begin
            d[6:0] = pal_shadow[offs[5:2]];
        end else if (offs == sam_mem_pkg::MODE_OFFS) begin
            d[0] = video_ctrl.mode;
        end else if (offs == sam_mem_pkg::BASE_OFFS) begin
            d[sam_mem_pkg::RAM_AW-1:0] = video_ctrl.base;
        end else if (offs == sam_mem_pkg::BORDER_OFFS) begin
            d[3:0] = video_ctrl.border;
        end
        return d;
    endfunction

    ////////////////////
    // Decode
    ////////////////////

    assign wr_req    = axil_req.aw_valid && axil_req.w_valid;
    assign rd_req    = axil_req.ar_valid;
    assign wr_is_reg = axil_req.aw_addr >= sam_mem_pkg::REG_BASE;
    assign rd_is_reg = axil_req.ar_addr >= sam_mem_pkg::REG_BASE;
    assign wr_offs   = axil_req.aw_addr[sam_mem_pkg::RAM_AW-1:0];
    assign rd_offs   = axil_req.ar_addr[sam_mem_pkg::RAM_AW-1:0];
    assign wr_is_pal = wr_offs[sam_mem_pkg::RAM_AW-1:6]
                       == sam_mem_pkg::PAL_OFFS[sam_mem_pkg::RAM_AW-1:6]
                       && wr_offs[1:0] == 2'b00;
    // Register writes complete in the idle state, writes win over reads
    assign reg_wr_en = (state == ST_IDLE) && wr_req && wr_is_reg;

    // RAM request held straight from the AXI channels until granted
    always_comb begin
        mem_req       = '0;
        mem_req.valid = (state == ST_RAM_WAIT);
        mem_req.we    = op_wr;
        mem_req.addr  = op_wr ? axil_req.aw_addr[sam_mem_pkg::RAM_AW-1:0] : rd_offs;
        mem_req.wdata = axil_req.w_data[7:0];
    end

    // Readies pulse when the access completes, responses always OKAY
    always_comb begin
        axil_rsp         = '0;
        axil_rsp.b_valid = (state == ST_WR_RESP);
        axil_rsp.r_valid = (state == ST_RD_RESP);
        axil_rsp.r_data  = r_data_q;
        case (state)
            ST_IDLE: begin
                if (wr_req && (wr_is_reg || !axil_req.w_strb[0])) begin
                    axil_rsp.aw_ready = 1'b1;
                    axil_rsp.w_ready  = 1'b1;
                end else if (!wr_req && rd_req && rd_is_reg) begin
                    axil_rsp.ar_ready = 1'b1;
                end
            end
            ST_RAM_WAIT: begin
                axil_rsp.aw_ready = mem_rsp.grant && op_wr;
                axil_rsp.w_ready  = mem_rsp.grant && op_wr;
                axil_rsp.ar_ready = mem_rsp.grant && !op_wr;
            end
            default: ;
        endcase
    end

    ////////////////////
    // FSM and registers
    ////////////////////

    always_ff @(posedge clk12 or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ST_IDLE;
            op_wr      <= 1'b0;
            video_ctrl <= '{mode: sam_video_pkg::MODE4, base: '0, border: '0};
            pal_wr     <= '0;
        end else begin
            pal_wr.valid  <= reg_wr_en && wr_is_pal;
            pal_wr.idx    <= wr_offs[5:2];
            pal_wr.colour <= axil_req.w_data[6:0];
            if (reg_wr_en) begin
                if (wr_offs == sam_mem_pkg::MODE_OFFS) begin
                    video_ctrl.mode <= sam_video_pkg::mode_e'(axil_req.w_data[0]);
                end
                if (wr_offs == sam_mem_pkg::BASE_OFFS) begin
                    video_ctrl.base <= axil_req.w_data[sam_mem_pkg::RAM_AW-1:0];
                end
                if (wr_offs == sam_mem_pkg::BORDER_OFFS) begin
                    video_ctrl.border <= axil_req.w_data[3:0];
                end
            end
            case (state)
                ST_IDLE: begin
                    if (wr_req) begin
                        op_wr <= 1'b1;
                        // Unstrobed RAM byte is dropped but still answered
                        state <= (wr_is_reg || !axil_req.w_strb[0]) ? ST_WR_RESP : ST_RAM_WAIT;
                    end else if (rd_req) begin
                        op_wr <= 1'b0;
                        state <= rd_is_reg ? ST_RD_RESP : ST_RAM_WAIT;
                    end
                end
                ST_RAM_WAIT: if (mem_rsp.grant) state <= op_wr ? ST_WR_RESP : ST_RD_WAIT;
                ST_RD_WAIT:  if (mem_rsp.rvalid) state <= ST_RD_RESP;
                ST_WR_RESP:  if (axil_req.b_ready) state <= ST_IDLE;
                ST_RD_RESP:  if (axil_req.r_ready) state <= ST_IDLE;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    // Palette copy for read back, and read data capture
    always_ff @(posedge clk12) begin
        if (reg_wr_en && wr_is_pal) begin
            pal_shadow[wr_offs[5:2]] <= axil_req.w_data[6:0];
        end
        if (state == ST_IDLE && !wr_req && rd_req && rd_is_reg) begin
            r_data_q <= reg_read(rd_offs);
        end else if (state == ST_RD_WAIT && mem_rsp.rvalid) begin
            r_data_q <= {24'h000000, mem_rsp.rdata};
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Held responses
    a_r_hold: assert property (@(posedge clk12) disable iff (!arst_n)
        axil_rsp.r_valid && !axil_req.r_ready |=> axil_rsp.r_valid && $stable(axil_rsp.r_data))
        else $error("r_valid dropped or r_data changed before r_ready");
    a_b_hold: assert property (@(posedge clk12) disable iff (!arst_n)
        axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid)
        else $error("b_valid dropped before b_ready");

endmodule

`default_nettype wire

// File: logic/sram_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module sram_arbiter (
    input  wire                      clk12,
    input  wire                      arst_n,
    input  wire sam_mem_pkg::mem_req_t video_req,
    output sam_mem_pkg::mem_rsp_t    video_rsp,
    input  wire sam_mem_pkg::mem_req_t cpu_req,
    output sam_mem_pkg::mem_rsp_t    cpu_rsp,
    output logic [sam_mem_pkg::RAM_AW-1:0] sram_addr,
    output logic                     sram_we_n,
    output logic [7:0]               sram_wdata,
    input  wire [7:0]                sram_rdata
);

    sam_mem_pkg::mem_req_t sel;
    // Owner of the read in flight
    logic vid_rd_q;
    logic cpu_rd_q;

    // Video has fixed priority
    always_comb begin
        video_rsp        = '0;
        cpu_rsp          = '0;
        video_rsp.grant  = video_req.valid;
        cpu_rsp.grant    = cpu_req.valid && !video_req.valid;
        video_rsp.rvalid = vid_rd_q;
        cpu_rsp.rvalid   = cpu_rd_q;
        // Shared read bus, rvalid tells who owns it
        video_rsp.rdata  = sram_rdata;
        cpu_rsp.rdata    = sram_rdata;
    end

    // Granted request drives the pins in the same clock
    assign sel        = video_req.valid ? video_req : cpu_req;
    assign sram_addr  = sel.addr;
    assign sram_we_n  = !(sel.valid && sel.we);
    assign sram_wdata = sel.wdata;

    always_ff @(posedge clk12 or negedge arst_n) begin
        if (!arst_n) begin
            vid_rd_q <= 1'b0;
            cpu_rd_q <= 1'b0;
        end else begin
            vid_rd_q <= video_rsp.grant && !video_req.we;
            cpu_rd_q <= cpu_rsp.grant && !cpu_req.we;
        end
    end

    // CPU request held steady until it wins the bus
    a_cpu_hold: assert property (@(posedge clk12) disable iff (!arst_n)
        cpu_req.valid && !cpu_rsp.grant |=> cpu_req.valid && $stable(cpu_req.addr)
            && $stable(cpu_req.we))
        else $error("CPU request dropped or changed before its grant");

endmodule

`default_nettype wire

// File: logic/video_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module video_fetch (
    input  wire                          clk12,
    input  wire                          arst_n,
    input  wire sam_video_pkg::video_ctrl_t video_ctrl,
    output sam_mem_pkg::mem_req_t        mem_req,
    input  wire sam_mem_pkg::mem_rsp_t     mem_rsp,
    output logic [3:0]                   pix_index,
    output logic                         pix_active,
    output logic                         hsync,
    output logic                         vsync
);

    logic [sam_video_pkg::X_W-1:0] x;
    logic [sam_video_pkg::Y_W-1:0] y;
    logic [sam_video_pkg::Y_W-1:0] fill_y;
    logic [3:0] fill_b;
    logic [3:0] fill_ptr;
    logic       fill_win;
    logic       mode4;
    logic [3:0] show_slot;
    logic [sam_mem_pkg::RAM_AW-1:0] line_offs;
    sam_video_pkg::screen_byte_u line_buf [sam_video_pkg::LINE_BYTES];
    sam_video_pkg::screen_byte_u cur_byte;

    ////////////////////
    // Raster counters
    ////////////////////

    always_ff @(posedge clk12 or negedge arst_n) begin
        if (!arst_n) begin
            x <= '0;
            y <= '0;
        end else if (x == sam_video_pkg::X_W'(sam_video_pkg::H_TOTAL - 1)) begin
            x <= '0;
            y <= (y == sam_video_pkg::Y_W'(sam_video_pkg::V_TOTAL - 1)) ? '0 : y + 1'b1;
        end else begin
            x <= x + 1'b1;
        end
    end

    assign pix_active = x < sam_video_pkg::H_ACTIVE && y < sam_video_pkg::V_ACTIVE;
    assign hsync = x >= sam_video_pkg::HSYNC_START && x < sam_video_pkg::HSYNC_END;
    assign vsync = y >= sam_video_pkg::VSYNC_START && y < sam_video_pkg::VSYNC_END;

    ////////////////////
    // Line fill
    ////////////////////

    assign mode4 = (video_ctrl.mode == sam_video_pkg::MODE4);
    // Next line to show, line 23 fills line 0
    assign fill_y = (y == sam_video_pkg::Y_W'(sam_video_pkg::V_TOTAL - 1)) ? '0 : y + 1'b1;
    // Blanking runs x 32..47, so low bits give the byte number
    assign fill_b   = x[3:0];
    assign fill_win = x >= sam_video_pkg::H_ACTIVE && fill_y < sam_video_pkg::V_ACTIVE;
    // 16 bytes per line in mode 4, 4 in mode 2
    assign line_offs = mode4 ? sam_mem_pkg::RAM_AW'({fill_y, 4'b0000})
                             : sam_mem_pkg::RAM_AW'({fill_y, 2'b00});

    always_comb begin
        mem_req       = '0;
        mem_req.valid = fill_win && (mode4 || fill_b[3:2] == 2'b00);
        mem_req.addr  = video_ctrl.base + line_offs + sam_mem_pkg::RAM_AW'(fill_b);
    end

    // Byte lands one clock after its grant
    always_ff @(posedge clk12 or negedge arst_n) begin
        if (!arst_n) begin
            fill_ptr <= '0;
            for (int i = 0; i < sam_video_pkg::LINE_BYTES; i++) begin
                line_buf[i] <= '0;
            end
        end else begin
            if (mem_rsp.grant) begin
                fill_ptr <= fill_b;
            end
            if (mem_rsp.rvalid) begin
                line_buf[fill_ptr].bits <= mem_rsp.rdata;
            end
        end
    end

    ////////////////////
    // Pixel index
    ////////////////////

    // Mode 4 two pixels per byte, mode 2 eight
    assign show_slot = mode4 ? x[4:1] : {2'b00, x[4:3]};
    assign cur_byte  = line_buf[show_slot];

    always_comb begin
        if (mode4) begin
            // High nibble is the left pixel
            pix_index = x[0] ? cur_byte.nib.lo : cur_byte.nib.hi;
        end else begin
            pix_index = {3'b000, cur_byte.bits[3'd7 - x[2:0]]};
        end
    end

    // A fill byte never lands in the slot on screen
    a_fill_blank: assert property (@(posedge clk12) disable iff (!arst_n)
        mem_rsp.rvalid && pix_active |-> fill_ptr != show_slot)
        else $error("line fill wrote the byte being shown");

endmodule

`default_nettype wire

// File: logic/video_palette.sv
`timescale 1ns/1ns
`default_nettype none

module video_palette (
    input  wire                          clk12,
    input  wire                          arst_n,
    input  wire sam_video_pkg::pal_wr_t    pal_wr,
    input  wire sam_video_pkg::video_ctrl_t video_ctrl,
    input  wire [3:0]                    pix_index,
    input  wire                          pix_active,
    input  wire                          hsync,
    input  wire                          vsync,
    output sam_video_pkg::colour_t       colour,
    output logic                         csync
);

    sam_video_pkg::colour_t pal_tab [sam_video_pkg::PAL_ENTRIES];
    sam_video_pkg::colour_t pix_colour;

    // Colour table, written from the bridge
    always_ff @(posedge clk12) begin
        if (pal_wr.valid) begin
            pal_tab[pal_wr.idx] <= pal_wr.colour;
        end
    end

    // Border entry outside the active area
    assign pix_colour = pix_active ? pal_tab[pix_index] : pal_tab[video_ctrl.border];

    // One register stage to the pins
    always_ff @(posedge clk12 or negedge arst_n) begin
        if (!arst_n) begin
            colour <= '0;
            csync  <= 1'b1;
        end else begin
            colour <= pix_colour;
            // Composite sync, active low
            csync  <= !(hsync || vsync);
        end
    end

endmodule

`default_nettype wire

// File: logic/sam_video_mem.sv
`timescale 1ns/1ns
`default_nettype none

module sam_video_mem (
    input  wire                      clk12,
    input  wire                      arst_n,
    input  wire sam_mem_pkg::axil_req_t axil_req,
    output sam_mem_pkg::axil_rsp_t   axil_rsp,
    output wire [sam_mem_pkg::RAM_AW-1:0] sram_addr,
    output wire                      sram_we_n,
    output wire [7:0]                sram_wdata,
    input  wire [7:0]                sram_rdata,
    output wire [2:0]                r,
    output wire [2:0]                g,
    output wire [2:0]                b,
    output wire                      csync
);

    sam_mem_pkg::mem_req_t      cpu_req;
    sam_mem_pkg::mem_rsp_t      cpu_rsp;
    sam_mem_pkg::mem_req_t      vid_req;
    sam_mem_pkg::mem_rsp_t      vid_rsp;
    sam_video_pkg::video_ctrl_t video_ctrl;
    sam_video_pkg::pal_wr_t     pal_wr;
    sam_video_pkg::colour_t     colour;
    logic [3:0] pix_index;
    logic       pix_active;
    logic       hsync;
    logic       vsync;

    // Bright goes out as the low bit of every gun
    assign r = {colour.r, colour.bright};
    assign g = {colour.g, colour.bright};
    assign b = {colour.b, colour.bright};

    cpu_bus_bridge u_bridge (
        .clk12      (clk12),
        .arst_n     (arst_n),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .mem_req    (cpu_req),
        .mem_rsp    (cpu_rsp),
        .video_ctrl (video_ctrl),
        .pal_wr     (pal_wr)
    );

    sram_arbiter u_arbiter (
        .clk12      (clk12),
        .arst_n     (arst_n),
        .video_req  (vid_req),
        .video_rsp  (vid_rsp),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .sram_addr  (sram_addr),
        .sram_we_n  (sram_we_n),
        .sram_wdata (sram_wdata),
        .sram_rdata (sram_rdata)
    );

    video_fetch u_fetch (
        .clk12      (clk12),
        .arst_n     (arst_n),
        .video_ctrl (video_ctrl),
        .mem_req    (vid_req),
        .mem_rsp    (vid_rsp),
        .pix_index  (pix_index),
        .pix_active (pix_active),
        .hsync      (hsync),
        .vsync      (vsync)
    );

    video_palette u_palette (
        .clk12      (clk12),
        .arst_n     (arst_n),
        .pal_wr     (pal_wr),
        .video_ctrl (video_ctrl),
        .pix_index  (pix_index),
        .pix_active (pix_active),
        .hsync      (hsync),
        .vsync      (vsync),
        .colour     (colour),
        .csync      (csync)
    );

endmodule

`default_nettype wire

// File: verif/tb_sram_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sram_model (
    input  wire                            clk,
    input  wire [sam_mem_pkg::RAM_AW-1:0]  addr,
    input  wire                            we_n,
    input  wire [7:0]                      wdata,
    output logic [7:0]                     rdata
);

    logic [7:0] mem [1 << sam_mem_pkg::RAM_AW];

    // Start-up contents, every address bit has a say
    initial begin
        for (int i = 0; i < (1 << sam_mem_pkg::RAM_AW); i++) begin
            mem[i] = i[7:0] ^ i[15:8] ^ {i[18:16], 5'b10110};
        end
    end

    // Synchronous write, registered read
    always @(posedge clk) begin
        if (!we_n) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: verif/tb_sam_video_mem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sam_video_mem;

    localparam int CLK_PERIOD  = 40;
    // About 8 frames of 1152 clocks plus CPU traffic, roughly doubled
    localparam int CYCLE_LIMIT = 20000;
    localparam logic [19:0] SCREEN_BASE = 20'h40000;

    logic clk12;
    logic arst_n;
    sam_mem_pkg::axil_req_t axil_req;
    sam_mem_pkg::axil_rsp_t axil_rsp;
    logic [sam_mem_pkg::RAM_AW-1:0] sram_addr;
    logic       sram_we_n;
    logic [7:0] sram_wdata;
    logic [7:0] sram_rdata;
    logic [2:0] r;
    logic [2:0] g;
    logic [2:0] b;
    logic       csync;

    logic [31:0] rng_state = 32'h34b0;
    int          cycles = 0;
    // Reference state
    logic [7:0]  ram_copy [int];
    logic [6:0]  pal_copy [16];
    logic        exp_mode4;
    logic [3:0]  exp_border;
    int          cur_x;
    int          cur_y;
    int          prev_x;
    int          prev_y;
    logic        prev_valid;
    int          frame_count;
    logic        video_on = 1'b0;

    sam_video_mem u_dut (
        .clk12      (clk12),
        .arst_n     (arst_n),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .sram_addr  (sram_addr),
        .sram_we_n  (sram_we_n),
        .sram_wdata (sram_wdata),
        .sram_rdata (sram_rdata),
        .r          (r),
        .g          (g),
        .b          (b),
        .csync      (csync)
    );

    tb_sram_model u_sram (
        .clk   (clk12),
        .addr  (sram_addr),
        .we_n  (sram_we_n),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    initial begin
        clk12 = 1'b0;
        forever #(CLK_PERIOD / 2) clk12 = !clk12;
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("** Error %s: expected %0h, actual %0h", test_name, expected, actual);
            stop_run("Value mismatch, run stopped");
        end
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Written byte, or the SRAM start-up pattern
    function automatic logic [7:0] ram_byte(input logic [18:0] a);
        if (ram_copy.exists(int'(a))) begin
            return ram_copy[int'(a)];
        end
        return a[7:0] ^ a[15:8] ^ {a[18:16], 5'b10110};
    endfunction

    // Screen colour at a raster position, from the address and mode rules
    function automatic logic [6:0] expected_colour(input int px, input int py);
        logic [7:0] sb;
        logic [3:0] idx;
        if (px >= 32 || py >= 16) begin
            return pal_copy[exp_border];
        end
        if (exp_mode4) begin
            sb  = ram_byte(19'(SCREEN_BASE + py * 16 + px / 2));
            idx = (px % 2 == 0) ? sb[7:4] : sb[3:0];
        end else begin
            sb  = ram_byte(19'(SCREEN_BASE + py * 4 + px / 8));
            idx = {3'b000, sb[7 - px % 8]};
        end
        return pal_copy[idx];
    endfunction

    // Pins r, g, b as two colour bits each followed by bright
    function automatic logic [8:0] colour_pins(input logic [6:0] c);
        return {c[6:5], c[0], c[4:3], c[0], c[2:1], c[0]};
    endfunction

    ////////////////////
    // AXI4-Lite master
    ////////////////////

    task automatic axi_write(input logic [19:0] addr, input logic [31:0] data);
        logic acc;
        int   stall;
        @(negedge clk12);
        axil_req.aw_valid = 1'b1;
        axil_req.aw_addr  = addr;
        axil_req.w_valid  = 1'b1;
        axil_req.w_data   = data;
        axil_req.w_strb   = 4'hf;
        acc = 1'b0;
        while (!acc) begin
            // Readies settle well before the next rising edge
            #(CLK_PERIOD / 4);
            acc = axil_rsp.aw_ready && axil_rsp.w_ready;
            @(negedge clk12);
        end
        axil_req.aw_valid = 1'b0;
        axil_req.w_valid  = 1'b0;
        while (!axil_rsp.b_valid) @(negedge clk12);
        check_value("write response", 32'h0, 32'(axil_rsp.b_resp));
        // Random back-pressure on B, a read knocks meanwhile
        stall = int'(next_rand() % 4);
        axil_req.ar_addr  = addr;
        axil_req.ar_valid = (stall != 0);
        repeat (stall) begin
            #(CLK_PERIOD / 4);
            if (axil_rsp.aw_ready || axil_rsp.w_ready || axil_rsp.ar_ready
                || !axil_rsp.b_valid) begin
                stop_run("Bridge changed state while the write response was held");
            end
            @(negedge clk12);
        end
        axil_req.ar_valid = 1'b0;
        axil_req.b_ready  = 1'b1;
        @(negedge clk12);
        axil_req.b_ready = 1'b0;
    endtask

    task automatic axi_read(input logic [19:0] addr, output logic [31:0] data);
        logic acc;
        int   stall;
        @(negedge clk12);
        axil_req.ar_valid = 1'b1;
        axil_req.ar_addr  = addr;
        acc = 1'b0;
        while (!acc) begin
            #(CLK_PERIOD / 4);
            acc = axil_rsp.ar_ready;
            @(negedge clk12);
        end
        axil_req.ar_valid = 1'b0;
        while (!axil_rsp.r_valid) @(negedge clk12);
        data  = axil_rsp.r_data;
        check_value("read response", 32'h0, 32'(axil_rsp.r_resp));
        // Random back-pressure on R, a write knocks meanwhile
        stall = int'(next_rand() % 4);
        axil_req.aw_addr  = addr;
        axil_req.aw_valid = (stall != 0);
        axil_req.w_valid  = (stall != 0);
        repeat (stall) begin
            #(CLK_PERIOD / 4);
            check_value("held read data", data, axil_rsp.r_data);
            if (axil_rsp.aw_ready || axil_rsp.w_ready || axil_rsp.ar_ready
                || !axil_rsp.r_valid) begin
                stop_run("Bridge accepted work while the read response was held");
            end
            @(negedge clk12);
        end
        axil_req.aw_valid = 1'b0;
        axil_req.w_valid  = 1'b0;
        axil_req.r_ready  = 1'b1;
        @(negedge clk12);
        axil_req.r_ready = 1'b0;
    endtask

    // RAM writes and read-back below the screen area, until a frame count
    task automatic ram_traffic(input int until_frame);
        logic [19:0] a;
        logic [7:0]  d;
        logic [31:0] rd;
        while (frame_count < until_frame) begin
            a = {2'b00, 18'(next_rand())};
            d = 8'(next_rand());
            axi_write(a, {24'h0, d});
            ram_copy[int'(a)] = d;
            axi_read(a, rd);
            check_value("ram read-back", {24'h0, d}, rd);
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frame_count + n;
        while (frame_count < target) @(negedge clk12);
    endtask

    ////////////////////
    // Raster reference
    ////////////////////

    always @(posedge clk12 or negedge arst_n) begin
        if (!arst_n) begin
            cur_x       <= 0;
            cur_y       <= 0;
            prev_valid  <= 1'b0;
            frame_count <= 0;
        end else begin
            prev_x     <= cur_x;
            prev_y     <= cur_y;
            prev_valid <= 1'b1;
            if (cur_x == sam_video_pkg::H_TOTAL - 1) begin
                cur_x <= 0;
                if (cur_y == sam_video_pkg::V_TOTAL - 1) begin
                    cur_y       <= 0;
                    frame_count <= frame_count + 1;
                end else begin
                    cur_y <= cur_y + 1;
                end
            end else begin
                cur_x <= cur_x + 1;
            end
        end
    end

    // Pins show the position of the previous edge
    always @(negedge clk12) begin
        if (arst_n && prev_valid) begin
            check_value("csync window", 32'(!((prev_x >= 36 && prev_x < 40)
                        || (prev_y >= 18 && prev_y < 20))), 32'(csync));
            if (video_on) begin
                check_value(exp_mode4 ? "mode 4 colour" : "mode 2 colour",
                            32'(colour_pins(expected_colour(prev_x, prev_y))),
                            32'({r, g, b}));
            end
        end
    end

    always @(posedge clk12) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_run("Timeout, the run did not finish within the cycle limit");
        end
    end

    a_b_held: assert property (@(posedge clk12) disable iff (!arst_n)
        axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid)
        else stop_run("b_valid dropped before b_ready");
    a_r_held: assert property (@(posedge clk12) disable iff (!arst_n)
        axil_rsp.r_valid && !axil_req.r_ready |=> axil_rsp.r_valid && $stable(axil_rsp.r_data))
        else stop_run("r_valid dropped or r_data moved before r_ready");

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        logic [31:0] rd;
        axil_req = '0;
        arst_n   = 1'b0;
        repeat (8) @(negedge clk12);
        check_value("reset b_valid", 32'h0, 32'(axil_rsp.b_valid));
        check_value("reset r_valid", 32'h0, 32'(axil_rsp.r_valid));
        check_value("reset readies", 32'h0,
                    32'({axil_rsp.aw_ready, axil_rsp.w_ready, axil_rsp.ar_ready}));
        check_value("reset sram_we_n", 32'h1, 32'(sram_we_n));
        check_value("reset csync", 32'h1, 32'(csync));
        arst_n = 1'b1;

        // Palette, then control registers
        for (int i = 0; i < 16; i++) begin
            pal_copy[i] = 7'(next_rand());
            axi_write(20'h80000 + 20'(i * 4), {25'h0, pal_copy[i]});
        end
        for (int i = 0; i < 16; i++) begin
            axi_read(20'h80000 + 20'(i * 4), rd);
            check_value("palette read-back", {25'h0, pal_copy[i]}, rd);
        end
        exp_mode4  = 1'b1;
        exp_border = 4'(next_rand());
        axi_write(20'h80040, 32'h1);
        axi_write(20'h80044, {12'h0, SCREEN_BASE});
        axi_write(20'h80048, {28'h0, exp_border});
        axi_read(20'h80040, rd);
        check_value("mode read-back", 32'h1, rd);
        axi_read(20'h80044, rd);
        check_value("base read-back", {12'h0, SCREEN_BASE}, rd);
        axi_read(20'h80048, rd);
        check_value("border read-back", {28'h0, exp_border}, rd);
        axi_read(20'h8004c, rd);
        check_value("unmapped read", 32'h0, rd);
        axi_read(20'h8013c, rd);
        check_value("unmapped read", 32'h0, rd);

        // Mode 4 screen under CPU traffic
        wait_frames(2);
        video_on = 1'b1;
        ram_traffic(frame_count + 2);
        video_on = 1'b0;

        // Mode 2 screen
        exp_mode4 = 1'b0;
        axi_write(20'h80040, 32'h0);
        axi_read(20'h80040, rd);
        check_value("mode read-back", 32'h0, rd);
        wait_frames(2);
        video_on = 1'b1;
        ram_traffic(frame_count + 1);
        @(negedge clk12);
        video_on = 1'b0;

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
logic/sam_mem_pkg.sv
logic/sam_video_pkg.sv
logic/cpu_bus_bridge.sv
logic/sram_arbiter.sv
logic/video_fetch.sv
logic/video_palette.sv
logic/sam_video_mem.sv
verif/tb_sram_model.sv
verif/tb_sam_video_mem.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_sam_video_mem \
    -f build.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "Test OK" &&
echo "simulation passed" ||
{ echo "simulation did not pass"; exit 1; }
